/* verilog.f */
+incdir+hw
hw/cpu_ifs.sv
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/cpu_mem.sv
hw/cpu_top.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f verilog.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module cpu_tb

clean:
	rm -rf obj_dir

/* sim/cpu_tb.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int N_TESTS     = 5;
    localparam int TEST_CYCLES = 200;
    localparam int HALT_WAIT   = 100;

    localparam logic [`REG_AW-1:0] R0 = 2'd0;
    localparam logic [`REG_AW-1:0] R1 = 2'd1;
    localparam logic [`REG_AW-1:0] R2 = 2'd2;
    localparam logic [`REG_AW-1:0] R3 = 2'd3;

    logic               clk;
    logic               rst;
    logic [`DATA_W-1:0] in_port;
    logic               prog_we;
    logic [`DATA_W-1:0] prog_addr;
    logic [`DATA_W-1:0] prog_data;
    logic               hlt;
    logic [`DATA_W-1:0] out_port;

    // Program bytes for the current test from address 0
    logic [`DATA_W-1:0] program_q [$];

    cpu_top dut (
        .clk       (clk),
        .rst       (rst),
        .in_port   (in_port),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .hlt       (hlt),
        .out_port  (out_port)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    task automatic check_data(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] @ %0d ns: %s is 8'h%02h, expected 8'h%02h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] @ %0d ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic logic [`DATA_W-1:0] rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[`DATA_W-1:0];
    endfunction

    function automatic void emit(input logic [`OP_W-1:0] op, input logic [`REG_AW-1:0] ra,
                                 input logic [`REG_AW-1:0] rb);
        program_q.push_back({op, ra, rb});
    endfunction

    function automatic void emit_ldm(input logic [`REG_AW-1:0] ra,
                                     input logic [`DATA_W-1:0] value);
        emit(`OP_LDM, ra, R0);
        program_q.push_back(value);
    endfunction

    // Load the program in reset and let the core run
    task automatic run_program();
        logic [`DATA_W-1:0] addr;
        addr = '0;
        // NOP padding covers the bytes fetched past HLT
        repeat (4) emit(`OP_NOP, R0, R0);
        @(negedge clk);
        rst = 1'b1;
        foreach (program_q[i]) begin
            prog_we   = 1'b1;
            prog_addr = addr;
            prog_data = program_q[i];
            addr      = addr + 8'd1;
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (hlt !== 1'b1) begin
            if (cycles == HALT_WAIT) begin
                $display("hlt did not rise within %0d cycles of starting the program", HALT_WAIT);
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic test_reset_state();
        program_q.delete();
        emit(`OP_NOP, R0, R0);
        emit(`OP_NOP, R0, R0);
        emit(`OP_HLT, R0, R0);
        run_program();
        repeat (3) begin
            @(negedge clk);
            check_bit(hlt, 1'b0, "hlt after reset");
            check_data(out_port, '0, "out_port after reset");
        end
        wait_for_halt();
        check_data(out_port, '0, "out_port with no OUT");
    endtask

    task automatic test_alu_chain();
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] r0;
        logic [`DATA_W-1:0] r1;
        logic [`DATA_W-1:0] r2;
        a = rand_byte();
        b = rand_byte();
        program_q.delete();
        emit_ldm(R0, a);
        emit_ldm(R1, b);
        emit(`OP_ADD, R0, R1);
        emit(`OP_SUB, R1, R0);
        emit(`OP_AND, R0, R1);
        emit(`OP_OR,  R1, R0);
        emit(`OP_NOT, R0, R0);
        emit(`OP_INC, R1, R0);
        emit(`OP_MOV, R2, R1);
        emit(`OP_ADD, R2, R0);
        emit(`OP_OUT, R2, R0);
        emit(`OP_HLT, R0, R0);
        // Reference result modulo 256 through the 8-bit width
        r0 = a;
        r1 = b;
        r0 = r0 + r1;
        r1 = r1 - r0;
        r0 = r0 & r1;
        r1 = r1 | r0;
        r0 = ~r0;
        r1 = r1 + 8'd1;
        r2 = r1;
        r2 = r2 + r0;
        run_program();
        wait_for_halt();
        check_data(out_port, r2, "ALU chain result");
    endtask

    task automatic test_load_use();
        logic [`DATA_W-1:0] v;
        logic [`DATA_W-1:0] k;
        v = rand_byte();
        k = rand_byte();
        program_q.delete();
        emit_ldm(R0, v);
        emit_ldm(R1, 8'h80);
        emit_ldm(R3, k);
        emit(`OP_ST,  R0, R1);
        emit(`OP_LD,  R2, R1);
        emit(`OP_ADD, R2, R3);
        emit(`OP_OUT, R2, R0);
        emit(`OP_HLT, R0, R0);
        run_program();
        wait_for_halt();
        check_data(out_port, v + k, "load-use result");
    endtask

    task automatic test_input_port();
        logic [`DATA_W-1:0] x;
        x = rand_byte();
        in_port = x;
        program_q.delete();
        emit(`OP_IN,  R1, R0);
        emit(`OP_INC, R1, R0);
        emit(`OP_OUT, R1, R0);
        emit(`OP_HLT, R0, R0);
        run_program();
        wait_for_halt();
        check_data(out_port, x + 8'd1, "in_port plus one");
    endtask

    task automatic test_halt();
        logic [`DATA_W-1:0] x;
        logic [`DATA_W-1:0] y;
        x = rand_byte();
        y = x ^ 8'h5a;
        program_q.delete();
        emit_ldm(R0, x);
        emit_ldm(R1, y);
        emit(`OP_OUT, R0, R0);
        emit(`OP_HLT, R0, R0);
        // Must never reach the output
        emit(`OP_OUT, R1, R0);
        run_program();
        wait_for_halt();
        repeat (20) begin
            check_bit(hlt, 1'b1, "hlt after HLT");
            check_data(out_port, x, "out_port after HLT");
            @(negedge clk);
        end
    endtask

    initial begin
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        stop_on_failure();
    end

    initial begin
        void'($urandom(32'he9a1_bd4d));
        rst       = 1'b1;
        in_port   = '0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (3) @(negedge clk);
        test_alu_chain();
        test_load_use();
        test_input_port();
        test_halt();
        test_reset_state();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* sim/cpu_sva.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_sva (
    input logic               clk,
    input logic               rst,
    input logic               hlt,
    input logic [`DATA_W-1:0] out_port
);

    // Halt is sticky until the next reset
    hlt_sticky: assert property (@(posedge clk) (hlt && !rst) |=> (hlt || rst))
        else $error("hlt fell while rst was low");

    out_known: assert property (@(posedge clk) !rst |-> !$isunknown(out_port))
        else $error("out_port has unknown bits outside reset");

    hlt_cleared: assert property (@(posedge clk) rst |=> !hlt)
        else $error("hlt high in the cycle after rst");

endmodule

bind cpu_top cpu_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .hlt      (hlt),
    .out_port (out_port)
);

/* hw/cpu_top.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_top import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [`DATA_W-1:0] in_port,
    input  logic               prog_we,
    input  logic [`DATA_W-1:0] prog_addr,
    input  logic [`DATA_W-1:0] prog_data,
    output logic               hlt,
    output logic [`DATA_W-1:0] out_port
);

    logic [`DATA_W-1:0] instr_addr;
    instr_u             instr_data;
    instr_u             ir;
    logic [`DATA_W-1:0] imm;
    logic               fd_valid;
    logic               stall;

    logic               wb_en;
    logic [`REG_AW-1:0] wb_addr;
    logic [`DATA_W-1:0] wb_data;

    logic [`DATA_W-1:0] data_addr;
    logic [`DATA_W-1:0] data_wdata;
    logic               data_we;
    logic [`DATA_W-1:0] data_rdata;

    ex_pipe_if  ex_if ();
    mem_pipe_if mem_if ();

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .ir         (ir),
        .imm        (imm),
        .fd_valid   (fd_valid)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .ir       (ir),
        .imm      (imm),
        .fd_valid (fd_valid),
        .stall    (stall),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .ex       (ex_if.drive)
    );

    execute_stage u_execute (
        .clk     (clk),
        .rst     (rst),
        .in_port (in_port),
        .ex      (ex_if.sink),
        .mem     (mem_if.drive),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    mem_wb_stage u_mem_wb (
        .clk        (clk),
        .rst        (rst),
        .mem        (mem_if.sink),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .out_port   (out_port),
        .hlt        (hlt)
    );

    cpu_mem u_mem (
        .clk        (clk),
        .rst        (rst),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata)
    );

endmodule

/* hw/cpu_mem.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_mem import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               prog_we,
    input  logic [`DATA_W-1:0] prog_addr,
    input  logic [`DATA_W-1:0] prog_data,
    input  logic [`DATA_W-1:0] instr_addr,
    output instr_u             instr_data,
    input  logic [`DATA_W-1:0] data_addr,
    input  logic [`DATA_W-1:0] data_wdata,
    input  logic               data_we,
    output logic [`DATA_W-1:0] data_rdata
);

    logic [`DATA_W-1:0] ram [`MEM_DEPTH];

    // Program load only while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst) begin
            if (prog_we) begin
                ram[prog_addr] <= prog_data;
            end
        end else if (data_we) begin
            ram[data_addr] <= data_wdata;
        end
    end

    assign instr_data = ram[instr_addr];
    assign data_rdata = ram[data_addr];

endmodule

/* hw/mem_wb_stage.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module mem_wb_stage (
    input  logic               clk,
    input  logic               rst,
    mem_pipe_if.sink           mem,
    output logic [`DATA_W-1:0] data_addr,
    output logic [`DATA_W-1:0] data_wdata,
    output logic               data_we,
    input  logic [`DATA_W-1:0] data_rdata,
    output logic               wb_en,
    output logic [`REG_AW-1:0] wb_addr,
    output logic [`DATA_W-1:0] wb_data,
    output logic [`DATA_W-1:0] out_port,
    output logic               hlt
);

    logic out_ld_q;

    assign data_addr  = mem.res;
    assign data_wdata = mem.store_data;
    assign data_we    = mem.mem_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en    <= 1'b0;
            out_ld_q <= 1'b0;
            out_port <= '0;
            hlt      <= 1'b0;
        end else begin
            wb_en    <= mem.wr_en;
            out_ld_q <= mem.out_ld;
            // Sticky until reset
            if (mem.halt) begin
                hlt <= 1'b1;
            end
            if (out_ld_q) begin
                out_port <= wb_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= mem.wr_addr;
        wb_data <= mem.mem_rd ? data_rdata : mem.res;
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic [`DATA_W-1:0] in_port,
    ex_pipe_if.sink            ex,
    mem_pipe_if.drive          mem,
    input  logic               wb_en,
    input  logic [`REG_AW-1:0] wb_addr,
    input  logic [`DATA_W-1:0] wb_data
);

    logic               mem_fwd_ok;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] result;

    // A load's res is still an address and the stall covers that case
    assign mem_fwd_ok = mem.wr_en && !mem.mem_rd;

    // Newest producer wins
    function automatic logic [`DATA_W-1:0] fwd(input logic [`REG_AW-1:0] src,
                                               input logic [`DATA_W-1:0] val);
        if (mem_fwd_ok && mem.wr_addr == src) begin
            return mem.res;
        end else if (wb_en && wb_addr == src) begin
            return wb_data;
        end
        return val;
    endfunction

    assign op_a = fwd(ex.src_a, ex.val_a);
    assign op_b = ex.b_is_imm ? ex.val_b : fwd(ex.src_b, ex.val_b);

    always_comb begin
        case (ex.alu_sel)
            `ALU_ADD:     result = op_a + op_b;
            `ALU_SUB:     result = op_a - op_b;
            `ALU_AND:     result = op_a & op_b;
            `ALU_OR:      result = op_a | op_b;
            `ALU_NOT:     result = ~op_a;
            `ALU_INC:     result = op_a + 1'b1;
            `ALU_PASS_IN: result = in_port;
            default:      result = op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem.wr_en  <= 1'b0;
            mem.mem_rd <= 1'b0;
            mem.mem_wr <= 1'b0;
            mem.out_ld <= 1'b0;
            mem.halt   <= 1'b0;
        end else begin
            mem.wr_en  <= ex.wr_en;
            mem.mem_rd <= ex.mem_rd;
            mem.mem_wr <= ex.mem_wr;
            mem.out_ld <= ex.out_ld;
            mem.halt   <= ex.halt;
        end
    end

    always_ff @(posedge clk) begin
        mem.wr_addr    <= ex.wr_addr;
        mem.res        <= result;
        // ST data is ra after forwarding
        mem.store_data <= op_a;
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  instr_u             ir,
    input  logic [`DATA_W-1:0] imm,
    input  logic               fd_valid,
    output logic               stall,
    input  logic               wb_en,
    input  logic [`REG_AW-1:0] wb_addr,
    input  logic [`DATA_W-1:0] wb_data,
    ex_pipe_if.drive           ex
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    logic [`OP_W-1:0]   op;
    logic               is_alu2;
    logic               dec_wr;
    logic               uses_a;
    logic               uses_b;
    logic [`ALU_W-1:0]  dec_alu;
    logic [`REG_AW-1:0] addr_a;
    logic [`REG_AW-1:0] addr_b;
    logic [`DATA_W-1:0] rd_a;
    logic [`DATA_W-1:0] rd_b;
    logic               halted;
    logic               load_use;
    logic               issue;

    assign op      = ir.f.opcode;
    assign is_alu2 = op inside {`OP_ADD, `OP_SUB, `OP_AND, `OP_OR};
    assign dec_wr  = is_alu2 || op inside {`OP_MOV, `OP_NOT, `OP_INC, `OP_IN, `OP_LD, `OP_LDM};
    assign uses_a  = is_alu2 || op inside {`OP_NOT, `OP_INC, `OP_ST};
    assign uses_b  = is_alu2 || op inside {`OP_MOV, `OP_OUT, `OP_LD, `OP_ST};

    always_comb begin
        case (op)
            `OP_ADD: dec_alu = `ALU_ADD;
            `OP_SUB: dec_alu = `ALU_SUB;
            `OP_AND: dec_alu = `ALU_AND;
            `OP_OR:  dec_alu = `ALU_OR;
            `OP_NOT: dec_alu = `ALU_NOT;
            `OP_INC: dec_alu = `ALU_INC;
            `OP_IN:  dec_alu = `ALU_PASS_IN;
            default: dec_alu = `ALU_PASS_B;
        endcase
    end

    // OUT sends ra through the b operand
    assign addr_a = ir.f.ra;
    assign addr_b = (op == `OP_OUT) ? ir.f.ra : ir.f.rb;

    // Write-through read ports
    assign rd_a = (wb_en && wb_addr == addr_a) ? wb_data : regs[addr_a];
    assign rd_b = (wb_en && wb_addr == addr_b) ? wb_data : regs[addr_b];

    assign load_use = fd_valid && ex.mem_rd &&
                      ((uses_a && ex.wr_addr == addr_a) || (uses_b && ex.wr_addr == addr_b));
    assign stall    = halted || load_use;
    assign issue    = fd_valid && !stall;

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            halted    <= 1'b0;
            ex.wr_en  <= 1'b0;
            ex.mem_rd <= 1'b0;
            ex.mem_wr <= 1'b0;
            ex.out_ld <= 1'b0;
            ex.halt   <= 1'b0;
        end else begin
            if (issue && op == `OP_HLT) begin
                halted <= 1'b1;
            end
            // Bubble whenever nothing issues
            ex.wr_en  <= issue && dec_wr;
            ex.mem_rd <= issue && op == `OP_LD;
            ex.mem_wr <= issue && op == `OP_ST;
            ex.out_ld <= issue && op == `OP_OUT;
            ex.halt   <= issue && op == `OP_HLT;
        end
    end

    always_ff @(posedge clk) begin
        ex.wr_addr  <= ir.f.ra;
        ex.alu_sel  <= dec_alu;
        ex.src_a    <= addr_a;
        ex.src_b    <= addr_b;
        ex.val_a    <= rd_a;
        ex.val_b    <= (op == `OP_LDM) ? imm : rd_b;
        ex.b_is_imm <= (op == `OP_LDM);
    end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    output logic [`DATA_W-1:0] instr_addr,
    input  instr_u             instr_data,
    output instr_u             ir,
    output logic [`DATA_W-1:0] imm,
    output logic               fd_valid
);

    logic [`DATA_W-1:0] pc;
    // Next byte is the LDM immediate
    logic               imm_next;

    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            imm_next <= 1'b0;
            fd_valid <= 1'b0;
        end else if (!stall) begin
            pc <= pc + 1'b1;
            if (imm_next) begin
                imm_next <= 1'b0;
                fd_valid <= 1'b1;
            end else if (instr_data.f.opcode == `OP_LDM) begin
                // Hold LDM back until its immediate is in
                imm_next <= 1'b1;
                fd_valid <= 1'b0;
            end else begin
                fd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (imm_next) begin
                imm <= instr_data.imm;
            end else begin
                ir <= instr_data;
            end
        end
    end

endmodule

/* hw/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

    typedef struct packed {
        logic [`OP_W-1:0]   opcode;
        logic [`REG_AW-1:0] ra;
        logic [`REG_AW-1:0] rb;
    } instr_fields_t;

    // A program byte is either an instruction or the LDM immediate
    typedef union packed {
        instr_fields_t      f;
        logic [`DATA_W-1:0] imm;
    } instr_u;

endpackage

/* hw/cpu_ifs.sv */
`timescale 1ns/100ps
`include "cpu_defs.svh"

// Decode/execute pipeline register
interface ex_pipe_if;
    logic                wr_en;
    logic [`REG_AW-1:0]  wr_addr;
    logic                mem_rd;
    logic                mem_wr;
    logic                out_ld;
    logic                halt;
    logic [`ALU_W-1:0]   alu_sel;
    logic [`REG_AW-1:0]  src_a;
    logic [`REG_AW-1:0]  src_b;
    logic [`DATA_W-1:0]  val_a;
    logic [`DATA_W-1:0]  val_b;
    // Set when val_b holds the LDM immediate
    logic                b_is_imm;

    modport drive (output wr_en, wr_addr, mem_rd, mem_wr, out_ld, halt, alu_sel,
                   src_a, src_b, val_a, val_b, b_is_imm);
    modport sink  (input  wr_en, wr_addr, mem_rd, mem_wr, out_ld, halt, alu_sel,
                   src_a, src_b, val_a, val_b, b_is_imm);
endinterface

// Execute/memory pipeline register
interface mem_pipe_if;
    logic                wr_en;
    logic [`REG_AW-1:0]  wr_addr;
    logic                mem_rd;
    logic                mem_wr;
    logic                out_ld;
    logic                halt;
    logic [`DATA_W-1:0]  res;
    logic [`DATA_W-1:0]  store_data;

    modport drive (output wr_en, wr_addr, mem_rd, mem_wr, out_ld, halt, res, store_data);
    modport sink  (input  wr_en, wr_addr, mem_rd, mem_wr, out_ld, halt, res, store_data);
endinterface

/* hw/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath sizes
`define DATA_W    8
`define REG_AW    2
`define NUM_REGS  4
`define MEM_DEPTH 256
`define OP_W      4
`define ALU_W     3

// Opcodes in instruction bits 7..4
`define OP_NOP 4'h0
`define OP_MOV 4'h1
`define OP_ADD 4'h2
`define OP_SUB 4'h3
`define OP_AND 4'h4
`define OP_OR  4'h5
`define OP_NOT 4'h6
`define OP_INC 4'h7
`define OP_IN  4'h8
`define OP_OUT 4'h9
`define OP_LD  4'hA
`define OP_ST  4'hB
`define OP_LDM 4'hC
`define OP_HLT 4'hD

// Execute result select
`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_NOT     3'd4
`define ALU_INC     3'd5
`define ALU_PASS_B  3'd6
`define ALU_PASS_IN 3'd7

`endif
